//--- tb.f
logic/bus_pkg.sv
logic/wb_host_master.sv
logic/wb_space_router.sv
logic/wb_sram.sv
logic/io_byte_port.sv
logic/bus_system_top.sv
tests/bus_checker.sv
tests/tb_top.sv

//--- tests/tb_top.sv
`timescale 1ns/1ns

module tb_top;
  import bus_pkg::*;

  localparam int              MEM_WORDS  = 256;    // small, so aliasing is cheap to reach.
  localparam logic [DATA_W-1:0] INT_VECTOR = 16'h0003;
  localparam int              PERIOD     = 4;
  localparam int              RST_CYCLES = 4;
  localparam int              N_WORDS    = 16;     // words in the memory tests.
  localparam int              N_IO       = 8;      // i/o port writes.
  // reset read, memory, byte lanes, i/o, unmapped i/o, inta, busy drop.
  localparam int              N_CMDS     = 1 + 4*N_WORDS + 3*N_IO + 3 + 3 + 3;

  logic              clk;
  logic              rst_n;
  logic              cmd_stb;
  cmd_op_e           cmd_op;
  logic [ADR_W-1:0]  cmd_adr;
  logic [DATA_W-1:0] cmd_dat;
  logic [SEL_W-1:0]  cmd_sel;
  logic              done;
  logic              busy;
  logic [DATA_W-1:0] rd_dat;

  string             test_name = "reset";
  logic [31:0]       seed      = 32'h3f42_06ea;
  logic [ADR_W-1:0]  words [N_WORDS];              // addresses of the memory tests.
  logic [DATA_W-1:0] model_mem [MEM_WORDS];        // reference memory.
  logic [DATA_W-1:0] model_io  = '0;               // reference port register.
  logic [DATA_W-1:0] model_rd  = '0;               // read data holds across writes.

  initial clk = 1'b0;
  always #(PERIOD/2) clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model for each accepted command
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [DATA_W-1:0] predict_read(cmd_op_e op, logic [ADR_W-1:0] adr,
                                                     logic [DATA_W-1:0] dat,
                                                     logic [SEL_W-1:0] sel);
    int idx;
    idx = int'(adr % MEM_WORDS);                   // upper bits alias.
    case (op)
      CMD_MEM_RD: model_rd = model_mem[idx];
      CMD_MEM_WR:
      begin
        if (sel[0])
          model_mem[idx][7:0] = dat[7:0];
        if (sel[1])
          model_mem[idx][15:8] = dat[15:8];
      end
      CMD_IO_RD:
      begin
        if (adr == IO_LO_ADR)
          model_rd = {model_io[7:0], 8'h00};
        else if (adr == IO_HI_ADR)
          model_rd = {8'h00, model_io[15:8]};
        else
          model_rd = '0;
      end
      CMD_IO_WR:
      begin
        if (adr == IO_LO_ADR && sel[1])
          model_io[7:0] = dat[15:8];               // lanes cross over.
        else if (adr == IO_HI_ADR && sel[0])
          model_io[15:8] = dat[7:0];
      end
      CMD_INTA: model_rd = INT_VECTOR;
    endcase
    return model_rd;
  endfunction

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // drive one command strobe from 1 ns after a rising edge.
  task automatic strobe(cmd_op_e op, logic [ADR_W-1:0] adr, logic [DATA_W-1:0] dat,
                        logic [SEL_W-1:0] sel);
    cmd_op  = op;
    cmd_adr = adr;
    cmd_dat = dat;
    cmd_sel = sel;
    cmd_stb = 1'b1;
    @(posedge clk);
    #1;
    cmd_stb = 1'b0;
  endtask

  task automatic wait_done();
    int waited;
    waited = 0;
    while (done !== 1'b1 && waited < 8)            // bounded wait for the done pulse.
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    @(posedge clk);                                // done and busy fall here.
    #1;
  endtask

  task automatic issue(cmd_op_e op, logic [ADR_W-1:0] adr, logic [DATA_W-1:0] dat,
                       logic [SEL_W-1:0] sel);
    strobe(op, adr, dat, sel);
    wait_done();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    logic [31:0]      r;
    logic [ADR_W-1:0] a;
    rst_n   = 1'b0;
    cmd_stb = 1'b0;
    cmd_op  = CMD_MEM_RD;
    cmd_adr = '0;
    cmd_dat = '0;
    cmd_sel = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);                                // checker looks at reset values.
    #1;
    issue(CMD_IO_RD, IO_LO_ADR, '0, 2'b11);        // port register starts at zero.

    test_name = "mem_wr_rd";
    for (int i = 0; i < N_WORDS; i++)
    begin
      r = lcg_next();
      words[i] = ADR_W'(r[31:8] % MEM_WORDS);
      r = lcg_next();
      issue(CMD_MEM_WR, words[i], r[31:16], 2'b11);
    end
    for (int i = 0; i < N_WORDS; i++)
      issue(CMD_MEM_RD, words[i], '0, 2'b11);

    test_name = "byte_lanes";
    for (int i = 0; i < N_WORDS; i++)
    begin
      r = lcg_next();
      a = words[i] + ADR_W'(MEM_WORDS) * ADR_W'(r[10:8]);  // some land above the array.
      issue(CMD_MEM_WR, a, r[31:16], r[13:12]);
    end
    for (int i = 0; i < N_WORDS; i++)
      issue(CMD_MEM_RD, words[i], '0, 2'b11);

    test_name = "io_swap";
    for (int i = 0; i < N_IO; i++)
    begin
      r = lcg_next();
      issue(CMD_IO_WR, (i % 2) ? IO_HI_ADR : IO_LO_ADR, r[31:16], r[13:12]);
      issue(CMD_IO_RD, IO_LO_ADR, '0, 2'b11);
      issue(CMD_IO_RD, IO_HI_ADR, '0, 2'b11);
    end
    issue(CMD_IO_WR, IO_LO_ADR - ADR_W'(1), 16'hffff, 2'b11);  // unmapped, dropped.
    issue(CMD_IO_RD, IO_LO_ADR - ADR_W'(1), '0, 2'b11);
    issue(CMD_IO_RD, IO_HI_ADR + ADR_W'(1), '0, 2'b11);

    test_name = "inta";
    issue(CMD_INTA, words[0], 16'hdead, 2'b11);
    issue(CMD_MEM_RD, words[0], '0, 2'b11);
    issue(CMD_IO_RD, IO_LO_ADR, '0, 2'b11);

    test_name = "busy_drop";
    r = lcg_next();
    strobe(CMD_MEM_WR, words[1], r[31:16], 2'b11);
    strobe(CMD_MEM_WR, words[1], ~r[31:16], 2'b11);  // lands while busy.
    wait_done();
    issue(CMD_MEM_RD, words[1], '0, 2'b11);

    repeat (4) @(posedge clk);                     // room for a stray done.
    $display("checked %0d commands, %0d value errors, %0d timing errors",
             u_chk.n_checked, u_chk.value_errs, u_chk.timing_errs);
    if (u_chk.value_errs + u_chk.timing_errs == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial
  begin
    #((N_CMDS * 10 + RST_CYCLES) * PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Something failed");
    $finish;
  end

  bus_system_top #(
    .MEM_WORDS  (MEM_WORDS),
    .INT_VECTOR (INT_VECTOR)
  ) u_dut (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .cmd_stb_i (cmd_stb),
    .cmd_op_i  (cmd_op),
    .cmd_adr_i (cmd_adr),
    .cmd_dat_i (cmd_dat),
    .cmd_sel_i (cmd_sel),
    .done_o    (done),
    .rd_dat_o  (rd_dat),
    .busy_o    (busy)
  );

  bus_checker u_chk (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .cmd_stb_i (cmd_stb),
    .cmd_op_i  (cmd_op),
    .cmd_adr_i (cmd_adr),
    .cmd_dat_i (cmd_dat),
    .cmd_sel_i (cmd_sel),
    .busy_i    (busy),
    .done_i    (done),
    .rd_dat_i  (rd_dat)
  );

endmodule

//--- tests/bus_checker.sv
`timescale 1ns/1ns

module bus_checker (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        cmd_stb_i,
  input  bus_pkg::cmd_op_e            cmd_op_i,
  input  logic [bus_pkg::ADR_W-1:0]   cmd_adr_i,
  input  logic [bus_pkg::DATA_W-1:0]  cmd_dat_i,
  input  logic [bus_pkg::SEL_W-1:0]   cmd_sel_i,
  input  logic                        busy_i,
  input  logic                        done_i,
  input  logic [bus_pkg::DATA_W-1:0]  rd_dat_i
);
  import bus_pkg::*;

  int                value_errs  = 0;              // wrong read data.
  int                timing_errs = 0;              // done or busy out of step.
  int                n_checked   = 0;
  logic              pending     = 1'b0;           // one command in flight.
  logic              rst_seen    = 1'b0;
  logic              was_busy;                     // master busy up to this edge.
  int                cyc_cnt;                      // edges since the accepting edge.
  int                exp_lat;
  logic [DATA_W-1:0] exp_dat;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sampled on the rising edge while outputs still hold the old cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      pending  = 1'b0;
      rst_seen = 1'b0;
    end
    else
    begin
      was_busy = pending;                          // busy lasts through the done edge.
      if (!rst_seen)
      begin
        rst_seen = 1'b1;                           // first edge out of reset.
        if (done_i !== 1'b0)
        begin
          $display("done not low right after reset");
          timing_errs++;
        end
        if (rd_dat_i !== '0)
        begin
          $display("Fail %s: expected %h, got %h", tb_top.test_name, 16'h0000, rd_dat_i);
          value_errs++;
        end
      end
      if (busy_i !== was_busy)
      begin
        $display("Fail %s: expected busy %b, got %b", tb_top.test_name, was_busy, busy_i);
        timing_errs++;
      end
      if (pending)
      begin
        cyc_cnt++;
        if (done_i === 1'b1)
        begin
          pending = 1'b0;
          n_checked++;
          if (cyc_cnt != exp_lat)
          begin
            $display("%s: done came %0d cycles after the command instead of %0d",
                     tb_top.test_name, cyc_cnt, exp_lat);
            timing_errs++;
          end
          if (rd_dat_i !== exp_dat)
          begin
            $display("Fail %s: expected %h, got %h", tb_top.test_name, exp_dat, rd_dat_i);
            value_errs++;
          end
        end
        else if (cyc_cnt > exp_lat)
        begin
          $display("%s: no done within %0d cycles of the command", tb_top.test_name, exp_lat);
          timing_errs++;
          pending = 1'b0;
        end
      end
      else if (done_i === 1'b1)
      begin
        $display("%s: done pulse with no command in flight", tb_top.test_name);
        timing_errs++;
      end
      // a strobe only counts when the master is idle.
      if (cmd_stb_i && !was_busy)
      begin
        exp_dat = tb_top.predict_read(cmd_op_i, cmd_adr_i, cmd_dat_i, cmd_sel_i);
        exp_lat = (cmd_op_i == CMD_MEM_RD || cmd_op_i == CMD_MEM_WR) ? 3 : 2;
        cyc_cnt = 0;
        pending = 1'b1;
      end
    end
  end

endmodule

//--- logic/bus_system_top.sv
`timescale 1ns/1ns

module bus_system_top #(
  parameter int                         MEM_WORDS  = 4096,
  parameter logic [bus_pkg::DATA_W-1:0] INT_VECTOR = 16'd3
) (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        cmd_stb_i,
  input  bus_pkg::cmd_op_e            cmd_op_i,
  input  logic [bus_pkg::ADR_W-1:0]   cmd_adr_i,
  input  logic [bus_pkg::DATA_W-1:0]  cmd_dat_i,
  input  logic [bus_pkg::SEL_W-1:0]   cmd_sel_i,
  output logic                        done_o,
  output logic [bus_pkg::DATA_W-1:0]  rd_dat_o,
  output logic                        busy_o
);
  import bus_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // master bus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic              wb_cyc, wb_stb, wb_we, wb_tga, wb_inta, wb_ack;
  logic [ADR_W-1:0]  wb_adr;
  logic [SEL_W-1:0]  wb_sel;
  logic [DATA_W-1:0] wb_wdat, wb_rdat;
  // per-space strobes and returns.
  logic              mem_cyc, mem_stb, mem_ack, io_cyc, io_stb, io_ack;
  logic [DATA_W-1:0] mem_rdat, io_rdat;

  wb_host_master u_master (
    .clk       (clk),        .rst_n_i   (rst_n_i),
    .cmd_stb_i (cmd_stb_i),  .cmd_op_i  (cmd_op_i),
    .cmd_adr_i (cmd_adr_i),  .cmd_dat_i (cmd_dat_i),
    .cmd_sel_i (cmd_sel_i),  .done_o    (done_o),
    .busy_o    (busy_o),     .rd_dat_o  (rd_dat_o),
    .wb_cyc_o  (wb_cyc),     .wb_stb_o  (wb_stb),
    .wb_we_o   (wb_we),      .wb_tga_o  (wb_tga),
    .wb_inta_o (wb_inta),    .wb_adr_o  (wb_adr),
    .wb_sel_o  (wb_sel),     .wb_dat_o  (wb_wdat),
    .wb_ack_i  (wb_ack),     .wb_dat_i  (wb_rdat)
  );

  wb_space_router #(.INT_VECTOR(INT_VECTOR)) u_router (
    .wb_cyc_i  (wb_cyc),     .wb_stb_i  (wb_stb),
    .wb_tga_i  (wb_tga),     .wb_inta_i (wb_inta),
    .wb_ack_o  (wb_ack),     .wb_dat_o  (wb_rdat),
    .mem_cyc_o (mem_cyc),    .mem_stb_o (mem_stb),
    .mem_ack_i (mem_ack),    .mem_dat_i (mem_rdat),
    .io_cyc_o  (io_cyc),     .io_stb_o  (io_stb),
    .io_ack_i  (io_ack),     .io_dat_i  (io_rdat)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // slaves, address and write data shared
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  wb_sram #(.MEM_WORDS(MEM_WORDS)) u_sram (
    .clk   (clk),      .rst_n_i (rst_n_i),  .cyc_i (mem_cyc),  .stb_i (mem_stb),
    .we_i  (wb_we),    .adr_i   (wb_adr),   .sel_i (wb_sel),   .dat_i (wb_wdat),
    .ack_o (mem_ack),  .dat_o   (mem_rdat)
  );

  io_byte_port u_io (
    .clk   (clk),      .rst_n_i (rst_n_i),  .cyc_i (io_cyc),   .stb_i (io_stb),
    .we_i  (wb_we),    .adr_i   (wb_adr),   .sel_i (wb_sel),   .dat_i (wb_wdat),
    .ack_o (io_ack),   .dat_o   (io_rdat)
  );

endmodule

//--- logic/io_byte_port.sv
`timescale 1ns/1ns

module io_byte_port (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [bus_pkg::ADR_W-1:0]   adr_i,
  input  logic [bus_pkg::SEL_W-1:0]   sel_i,
  input  logic [bus_pkg::DATA_W-1:0]  dat_i,
  output logic                        ack_o,
  output logic [bus_pkg::DATA_W-1:0]  dat_o
);
  import bus_pkg::*;

  logic [DATA_W-1:0] io_q;                         // shared port register.
  logic              wr_en;                        // write strobe this edge.
  logic              hit_lo;
  logic              hit_hi;

  assign hit_lo = (adr_i == IO_LO_ADR);
  assign hit_hi = (adr_i == IO_HI_ADR);
  assign wr_en  = cyc_i & stb_i & we_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register update, lanes crossed
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      io_q <= '0;
    else if (wr_en)
    begin
      if (hit_lo && sel_i[1])
        io_q[7:0] <= dat_i[15:8];                  // high lane to low byte.
      else if (hit_hi && sel_i[0])
        io_q[15:8] <= dat_i[7:0];                  // low lane to high byte.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    if (hit_lo)
      dat_o = {io_q[7:0], 8'h00};                  // low byte back on high lane.
    else if (hit_hi)
      dat_o = {8'h00, io_q[15:8]};                 // high byte back on low lane.
    else
      dat_o = '0;                                  // unmapped port.
  end

  assign ack_o = stb_i;                            // zero wait states.

endmodule

//--- logic/wb_sram.sv
`timescale 1ns/1ns

module wb_sram #(
  parameter int MEM_WORDS = 4096
) (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [bus_pkg::ADR_W-1:0]   adr_i,
  input  logic [bus_pkg::SEL_W-1:0]   sel_i,
  input  logic [bus_pkg::DATA_W-1:0]  dat_i,
  output logic                        ack_o,
  output logic [bus_pkg::DATA_W-1:0]  dat_o
);
  import bus_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);        // depth is a power of two.

  logic [DATA_W-1:0] mem_q [MEM_WORDS];            // word array.
  logic [IDX_W-1:0]  idx;                          // low address bits.
  logic              req;                          // new request this cycle.
  logic              ack_q;
  logic [DATA_W-1:0] rdat_q;

  assign idx = adr_i[IDX_W-1:0];                   // upper address bits alias.
  assign req = cyc_i & stb_i & ~ack_q;             // no second ack back to back.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one wait state acknowledge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= req;                                // high for a single cycle.
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // array access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (req)
    begin
      if (we_i)
      begin
        for (int i = 0; i < SEL_W; i++)
        begin
          if (sel_i[i])
            mem_q[idx][8*i +: 8] <= dat_i[8*i +: 8];  // selected lanes only.
        end
      end
      rdat_q <= mem_q[idx];                        // registered read, lines up with ack.
    end
  end

  assign ack_o = ack_q;
  assign dat_o = rdat_q;

endmodule

//--- logic/wb_space_router.sv
`timescale 1ns/1ns

module wb_space_router #(
  parameter logic [bus_pkg::DATA_W-1:0] INT_VECTOR = 16'd3
) (
  // master side.
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_tga_i,
  input  logic                        wb_inta_i,
  output logic                        wb_ack_o,
  output logic [bus_pkg::DATA_W-1:0]  wb_dat_o,
  // memory space.
  output logic                        mem_cyc_o,
  output logic                        mem_stb_o,
  input  logic                        mem_ack_i,
  input  logic [bus_pkg::DATA_W-1:0]  mem_dat_i,
  // i/o space.
  output logic                        io_cyc_o,
  output logic                        io_stb_o,
  input  logic                        io_ack_i,
  input  logic [bus_pkg::DATA_W-1:0]  io_dat_i
);
  import bus_pkg::*;

  logic mem_sel;                                   // untagged, not inta.
  logic io_sel;                                    // tagged, not inta.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // request split
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign mem_sel = ~wb_tga_i & ~wb_inta_i;
  assign io_sel  =  wb_tga_i & ~wb_inta_i;

  assign mem_cyc_o = wb_cyc_i & mem_sel;
  assign mem_stb_o = wb_stb_i & mem_sel;
  assign io_cyc_o  = wb_cyc_i & io_sel;
  assign io_stb_o  = wb_stb_i & io_sel;            // neither space sees inta.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    if (wb_inta_i)
    begin
      wb_ack_o = wb_stb_i;                         // vector answers at once.
      wb_dat_o = INT_VECTOR;
    end
    else if (wb_tga_i)
    begin
      wb_ack_o = io_ack_i;
      wb_dat_o = io_dat_i;
    end
    else
    begin
      wb_ack_o = mem_ack_i;
      wb_dat_o = mem_dat_i;
    end
  end

endmodule

//--- logic/wb_host_master.sv
`timescale 1ns/1ns

module wb_host_master (
  input  logic                        clk,
  input  logic                        rst_n_i,
  // host command side.
  input  logic                        cmd_stb_i,
  input  bus_pkg::cmd_op_e            cmd_op_i,
  input  logic [bus_pkg::ADR_W-1:0]   cmd_adr_i,
  input  logic [bus_pkg::DATA_W-1:0]  cmd_dat_i,
  input  logic [bus_pkg::SEL_W-1:0]   cmd_sel_i,
  output logic                        done_o,
  output logic                        busy_o,
  output logic [bus_pkg::DATA_W-1:0]  rd_dat_o,
  // wishbone classic master side.
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output logic                        wb_tga_o,
  output logic                        wb_inta_o,
  output logic [bus_pkg::ADR_W-1:0]   wb_adr_o,
  output logic [bus_pkg::SEL_W-1:0]   wb_sel_o,
  output logic [bus_pkg::DATA_W-1:0]  wb_dat_o,
  input  logic                        wb_ack_i,
  input  logic [bus_pkg::DATA_W-1:0]  wb_dat_i
);
  import bus_pkg::*;

  mst_state_e        state_q;                      // master FSM.
  logic              take_cmd;                     // command accepted this edge.
  logic              ack_seen;                     // cycle ends this edge.
  logic              op_we;                        // decoded write enable.
  logic              op_tga;                       // decoded i/o tag.
  logic              op_inta;                      // decoded inta flag.
  logic              we_q;
  logic              tga_q;
  logic              inta_q;
  logic [ADR_W-1:0]  adr_q;
  logic [SEL_W-1:0]  sel_q;
  logic [DATA_W-1:0] dat_q;
  logic [DATA_W-1:0] rd_dat_q;

  assign take_cmd = (state_q == ST_IDLE) && cmd_stb_i;  // strobes while busy are dropped.
  assign ack_seen = (state_q == ST_BUS) && wb_ack_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcode decode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    op_we   = 1'b0;
    op_tga  = 1'b0;
    op_inta = 1'b0;
    case (cmd_op_i)
      CMD_MEM_WR: op_we = 1'b1;                    // untagged write.
      CMD_IO_RD:  op_tga = 1'b1;                   // tagged read.
      CMD_IO_WR:
      begin
        op_we  = 1'b1;
        op_tga = 1'b1;                             // tagged write.
      end
      CMD_INTA:   op_inta = 1'b1;                  // vector read, no slave.
      default:    op_we = 1'b0;                    // CMD_MEM_RD, plain read.
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FSM and control registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      state_q  <= ST_IDLE;
      we_q     <= 1'b0;
      tga_q    <= 1'b0;
      inta_q   <= 1'b0;
      rd_dat_q <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE: if (take_cmd) state_q <= ST_BUS;  // E0.
        ST_BUS:  if (wb_ack_i) state_q <= ST_DONE; // cyc/stb drop on this edge.
        default: state_q <= ST_IDLE;               // done lasts one cycle.
      endcase
      if (take_cmd)
      begin
        we_q   <= op_we;
        tga_q  <= op_tga;
        inta_q <= op_inta;
      end
      else if (ack_seen)
      begin
        we_q   <= 1'b0;                            // qualifiers idle between cycles.
        tga_q  <= 1'b0;
        inta_q <= 1'b0;
      end
      if (ack_seen && !we_q)
        rd_dat_q <= wb_dat_i;                      // writes keep the last read.
    end
  end

  // payload, latched with the command.
  always_ff @(posedge clk)
  begin
    if (take_cmd)
    begin
      adr_q <= cmd_adr_i;
      sel_q <= cmd_sel_i;
      dat_q <= cmd_dat_i;
    end
  end

  assign wb_cyc_o  = (state_q == ST_BUS);          // cyc and stb move together.
  assign wb_stb_o  = (state_q == ST_BUS);
  assign wb_we_o   = we_q;
  assign wb_tga_o  = tga_q;
  assign wb_inta_o = inta_q;
  assign wb_adr_o  = adr_q;
  assign wb_sel_o  = sel_q;
  assign wb_dat_o  = dat_q;
  assign done_o    = (state_q == ST_DONE);
  assign busy_o    = (state_q != ST_IDLE);         // host waits on this.
  assign rd_dat_o  = rd_dat_q;

endmodule

//--- logic/bus_pkg.sv
package bus_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int DATA_W = 16;                      // one bus word.
  localparam int ADR_W  = 19;                      // word address, byte bits 19..1.
  localparam int SEL_W  = DATA_W / 8;              // one select per byte lane.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // i/o port map
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Both ports sit on one 16-bit register with the byte lanes crossed over.
  localparam logic [ADR_W-1:0] IO_LO_ADR = 19'h0005b;  // high lane <-> low byte.
  localparam logic [ADR_W-1:0] IO_HI_ADR = 19'h0005c;  // low lane <-> high byte.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host commands and master FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [2:0] {
    CMD_MEM_RD = 3'd0,                             // memory read, tag low.
    CMD_MEM_WR = 3'd1,                             // memory write, tag low.
    CMD_IO_RD  = 3'd2,                             // i/o read, tag high.
    CMD_IO_WR  = 3'd3,                             // i/o write, tag high.
    CMD_INTA   = 3'd4                              // interrupt acknowledge.
  } cmd_op_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,                                // waiting for a command.
    ST_BUS  = 2'd1,                                // cyc/stb out, waiting for ack.
    ST_DONE = 2'd2                                 // one-cycle done pulse.
  } mst_state_e;

endpackage
